// ==== src.f ====
+incdir+verif
design/ec_pkg.sv
design/fp_mod_mul.sv
design/fp_mod_addsub.sv
design/ec_point_dbl.sv
design/ec_dbl_top.sv
verif/tb_ec_dbl.sv

// ==== Makefile ====
VERILATOR := verilator
VFLAGS    := --binary --timing -Wno-fatal
LINTFLAGS := --lint-only --timing -Wall
TOP       := tb_ec_dbl
RTL_TOP   := ec_dbl_top
FILELIST  := src.f
OBJ_DIR   := obj_dir
PASS_MSG  := Test completed successfully

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(OBJ_DIR)

// ==== verif/tb_ec_ref.svh ====
// Reference model for Jacobian point doubling on a curve with a = 0
// Plain modular arithmetic over the prime 65521, one step per equation
// The point at infinity (z = 0) comes back unchanged

`ifndef TB_EC_REF_SVH
`define TB_EC_REF_SVH

localparam int unsigned REF_P = 65521;  // Field modulus

function automatic int unsigned add_mod(input int unsigned a, input int unsigned b);
  return (a + b) % REF_P;
endfunction

// Offset by p so the difference never goes negative
function automatic int unsigned sub_mod(input int unsigned a, input int unsigned b);
  return (a + REF_P - b) % REF_P;
endfunction

function automatic int unsigned mul_mod(input int unsigned a, input int unsigned b);
  logic [63:0] prod;
  prod = 64'(a) * 64'(b);
  return 32'(prod % 64'(REF_P));
endfunction

// Returns {x3, y3, z3}
function automatic logic [47:0] double_point(input int unsigned x, input int unsigned y,
                                             input int unsigned z);
  int unsigned a, b, c, d, e;
  int unsigned x3, y3, z3;
  if (z == 0)
    return {x[15:0], y[15:0], z[15:0]};
  a  = mul_mod(y, y);                 // A = y^2
  b  = mul_mod(mul_mod(x, a), 4);     // B = 4xA
  c  = mul_mod(mul_mod(a, a), 8);     // C = 8A^2
  d  = mul_mod(3, mul_mod(x, x));     // D = 3x^2
  e  = add_mod(b, b);                 // E = 2B
  x3 = sub_mod(mul_mod(d, d), e);
  y3 = sub_mod(mul_mod(d, sub_mod(b, x3)), c);
  z3 = mul_mod(z, add_mod(y, y));
  return {x3[15:0], y3[15:0], z3[15:0]};
endfunction

`endif

// ==== verif/tb_ec_dbl.sv ====
// Testbench for the point doubling top level
// Random, infinity and edge points, output back-pressure and a held input valid
// A checker process compares every output transfer with the reference model

`timescale 1ns/1ns
`default_nettype none

module tb_ec_dbl;

  localparam int          CLK_PERIOD = 8;
  localparam logic [31:0] SEED       = 32'hd36f_f850;
  localparam int          N_RAND     = 200;  // Random points with nonzero z
  localparam int          N_INF      = 8;    // Points at infinity
  localparam int          N_EDGE     = 27;   // All combinations of 0, 1, p-1
  localparam int          N_BP       = 40;   // Under output back-pressure
  localparam int          N_CONT     = 30;   // With i_val never dropped
  localparam int          N_TOTAL    = N_RAND + N_INF + N_EDGE + N_BP + N_CONT;

  `include "tb_ec_ref.svh"

  logic        i_clk, i_rst, i_val, i_rdy;
  ec_pkg::fe_t i_x, i_y, i_z;
  ec_pkg::fe_t o_x, o_y, o_z;
  logic        o_rdy, o_val;

  logic [47:0] exp_q[$];          // Expected {x, y, z} in acceptance order
  int          n_acc   = 0;       // Points accepted
  int          n_res   = 0;       // Results taken
  int          n_mis   = 0;
  int          n_proto = 0;
  logic [31:0] drv_state = SEED;  // Stimulus generator
  logic [31:0] bp_state  = ~SEED; // Back-pressure generator
  bit          bp_mode   = 1'b0;
  ec_pkg::fe_t edge_v [3] = '{16'd0, 16'd1, 16'(REF_P - 1)};

  ec_dbl_top uut (
    .i_clk (i_clk),
    .i_rst (i_rst),
    .i_x   (i_x),
    .i_y   (i_y),
    .i_z   (i_z),
    .i_val (i_val),
    .o_rdy (o_rdy),
    .o_x   (o_x),
    .o_y   (o_y),
    .o_z   (o_z),
    .o_val (o_val),
    .i_rdy (i_rdy)
  );

  initial begin
    i_clk = 1'b0;
    forever #(CLK_PERIOD / 2) i_clk = ~i_clk;
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] v;
    v = s;
    v = v ^ (v << 13);
    v = v ^ (v >> 17);
    v = v ^ (v << 5);
    return v;
  endfunction

  // Uniform-ish field element below p
  function automatic ec_pkg::fe_t rand_fe();
    drv_state = xorshift32(drv_state);
    return ec_pkg::fe_t'(drv_state % REF_P);
  endfunction

  function automatic void print_counts();
    $display("Errors: %0d mismatches, %0d protocol; %0d points accepted, %0d results",
             n_mis, n_proto, n_acc, n_res);
  endfunction

  task automatic check_coord(input string name, input ec_pkg::fe_t got,
                             input ec_pkg::fe_t want);
    if (got !== want) begin
      $display("MISMATCH at %0t: result %0d %s got %h expected %h",
               $time, n_res, name, got, want);
      n_mis++;
    end
  endtask

  // Entered on a falling edge, returns on the falling edge after acceptance
  task automatic send_point(input ec_pkg::fe_t x, input ec_pkg::fe_t y,
                            input ec_pkg::fe_t z, input bit keep_val);
    i_x   = x;
    i_y   = y;
    i_z   = z;
    i_val = 1'b1;
    while (!o_rdy) @(negedge i_clk);
    exp_q.push_back(double_point(x, y, z));  // Taken on the coming rising edge
    n_acc++;
    @(negedge i_clk);
    if (o_rdy) begin
      $display("Error at %0t: o_rdy stayed high after a point was accepted", $time);
      n_proto++;
    end
    if (!keep_val) i_val = 1'b0;
  endtask

  task automatic idle_cycles();
    repeat (rand_fe() % 4) @(negedge i_clk);
  endtask

  // Checker that also drives i_rdy
  initial begin
    logic [47:0] want;
    logic [47:0] held;
    bit          hold_pend;
    int          stall_left;
    i_rdy      = 1'b0;
    hold_pend  = 1'b0;
    held       = '0;
    stall_left = 0;
    forever begin
      @(negedge i_clk);
      // Output refused last cycle must still be there unchanged
      if (hold_pend && (!o_val || {o_x, o_y, o_z} != held)) begin
        $display("Error at %0t: output changed while o_val was waiting for i_rdy", $time);
        n_proto++;
      end
      bp_state = xorshift32(bp_state);
      if (i_rst) begin
        i_rdy = 1'b0;
      end else if (stall_left > 0) begin
        i_rdy = 1'b0;
        stall_left--;
      end else if (bp_mode && bp_state[0]) begin
        i_rdy      = 1'b0;  // Span of 1 to 8 cycles
        stall_left = int'(bp_state[3:1]);
      end else begin
        i_rdy = 1'b1;
      end
      if (o_val && i_rdy) begin
        if (exp_q.size() == 0) begin
          $display("Error at %0t: result appeared with no point outstanding", $time);
          n_proto++;
        end else begin
          want = exp_q.pop_front();
          check_coord("o_x", o_x, want[47:32]);
          check_coord("o_y", o_y, want[31:16]);
          check_coord("o_z", o_z, want[15:0]);
        end
        n_res++;
      end
      hold_pend = o_val && !i_rdy;
      held      = {o_x, o_y, o_z};
    end
  end

  // Watchdog sized from the test count
  initial begin
    #(N_TOTAL * 200 * CLK_PERIOD);
    $display("Timeout: run did not finish within %0d cycles", N_TOTAL * 200);
    print_counts();
    $display("Test failed");
    $finish;
  end

  // Driver and sequence
  initial begin
    ec_pkg::fe_t x, y, z;
    i_rst = 1'b1;
    i_val = 1'b0;
    i_x   = '0;
    i_y   = '0;
    i_z   = '0;
    repeat (2) begin
      @(negedge i_clk);
      if (o_rdy !== 1'b0 || o_val !== 1'b0) begin
        $display("Error at %0t: o_rdy or o_val not low during reset", $time);
        n_proto++;
      end
    end
    i_rst = 1'b0;
    @(negedge i_clk);
    if (o_rdy !== 1'b1 || o_val !== 1'b0) begin
      $display("Error at %0t: o_rdy not high or o_val not low after reset", $time);
      n_proto++;
    end

    for (int i = 0; i < N_RAND; i++) begin
      x = rand_fe();
      y = rand_fe();
      z = rand_fe();
      if (z == '0) z = 16'd1;  // Keep these finite
      send_point(x, y, z, 1'b0);
      idle_cycles();
    end

    for (int i = 0; i < N_INF; i++) begin
      send_point(rand_fe(), rand_fe(), 16'd0, 1'b0);
      idle_cycles();
    end

    // Wrap and correction corners
    foreach (edge_v[i])
      foreach (edge_v[j])
        foreach (edge_v[k])
          send_point(edge_v[i], edge_v[j], edge_v[k], 1'b0);

    bp_mode = 1'b1;
    for (int i = 0; i < N_BP; i++) begin
      send_point(rand_fe(), rand_fe(), rand_fe(), 1'b0);
      idle_cycles();
    end

    // i_val stays high, o_rdy alone gates acceptance
    for (int i = 0; i < N_CONT; i++)
      send_point(rand_fe(), rand_fe(), rand_fe(), i != N_CONT - 1);
    i_val = 1'b0;

    wait (n_res == n_acc);
    bp_mode = 1'b0;
    repeat (20) @(negedge i_clk);  // Catch any stray result
    if (exp_q.size() != 0) begin
      $display("Error: %0d results still expected at the end of the run", exp_q.size());
      n_proto++;
    end

    print_counts();
    if (n_mis == 0 && n_proto == 0 && n_acc == n_res)
      $display("Test completed successfully");
    else
      $display("Test failed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== design/ec_dbl_top.sv ====
// Point doubling top level
// Scheduler plus one multiplier, one adder and one subtractor

`timescale 1ns/1ns
`default_nettype none

module ec_dbl_top (
  input  wire             i_clk,
  input  wire             i_rst,
  input  wire ec_pkg::fe_t i_x,
  input  wire ec_pkg::fe_t i_y,
  input  wire ec_pkg::fe_t i_z,
  input  wire             i_val,
  output logic            o_rdy,
  output ec_pkg::fe_t     o_x,
  output ec_pkg::fe_t     o_y,
  output ec_pkg::fe_t     o_z,
  output logic            o_val,
  input  wire             i_rdy
);

  // Request and response nets per unit
  ec_pkg::fe_t  mul_a, mul_b, mul_r;
  ec_pkg::tag_t mul_req_tag, mul_rsp_tag;
  logic         mul_req_val, mul_req_rdy, mul_rsp_val, mul_rsp_rdy;

  ec_pkg::fe_t  add_a, add_b, add_r;
  ec_pkg::tag_t add_req_tag, add_rsp_tag;
  logic         add_req_val, add_req_rdy, add_rsp_val, add_rsp_rdy;

  ec_pkg::fe_t  sub_a, sub_b, sub_r;
  ec_pkg::tag_t sub_req_tag, sub_rsp_tag;
  logic         sub_req_val, sub_req_rdy, sub_rsp_val, sub_rsp_rdy;

  ec_point_dbl dbl_u (
    .i_clk     (i_clk),
    .i_rst     (i_rst),
    .i_x       (i_x),
    .i_y       (i_y),
    .i_z       (i_z),
    .i_val     (i_val),
    .o_rdy     (o_rdy),
    .o_x       (o_x),
    .o_y       (o_y),
    .o_z       (o_z),
    .o_val     (o_val),
    .i_rdy     (i_rdy),
    .o_mul_a   (mul_a),
    .o_mul_b   (mul_b),
    .o_mul_tag (mul_req_tag),
    .o_mul_val (mul_req_val),
    .i_mul_rdy (mul_req_rdy),
    .i_mul_r   (mul_r),
    .i_mul_tag (mul_rsp_tag),
    .i_mul_val (mul_rsp_val),
    .o_mul_rdy (mul_rsp_rdy),
    .o_add_a   (add_a),
    .o_add_b   (add_b),
    .o_add_tag (add_req_tag),
    .o_add_val (add_req_val),
    .i_add_rdy (add_req_rdy),
    .i_add_r   (add_r),
    .i_add_tag (add_rsp_tag),
    .i_add_val (add_rsp_val),
    .o_add_rdy (add_rsp_rdy),
    .o_sub_a   (sub_a),
    .o_sub_b   (sub_b),
    .o_sub_tag (sub_req_tag),
    .o_sub_val (sub_req_val),
    .i_sub_rdy (sub_req_rdy),
    .i_sub_r   (sub_r),
    .i_sub_tag (sub_rsp_tag),
    .i_sub_val (sub_rsp_val),
    .o_sub_rdy (sub_rsp_rdy)
  );

  fp_mod_mul mul_u (
    .i_clk (i_clk),
    .i_rst (i_rst),
    .i_a   (mul_a),
    .i_b   (mul_b),
    .i_tag (mul_req_tag),
    .i_val (mul_req_val),
    .o_rdy (mul_req_rdy),
    .o_r   (mul_r),
    .o_tag (mul_rsp_tag),
    .o_val (mul_rsp_val),
    .i_rdy (mul_rsp_rdy)
  );

  fp_mod_addsub #(.IS_SUB(1'b0)) add_u (
    .i_clk (i_clk),
    .i_rst (i_rst),
    .i_a   (add_a),
    .i_b   (add_b),
    .i_tag (add_req_tag),
    .i_val (add_req_val),
    .o_rdy (add_req_rdy),
    .o_r   (add_r),
    .o_tag (add_rsp_tag),
    .o_val (add_rsp_val),
    .i_rdy (add_rsp_rdy)
  );

  fp_mod_addsub #(.IS_SUB(1'b1)) sub_u (
    .i_clk (i_clk),
    .i_rst (i_rst),
    .i_a   (sub_a),
    .i_b   (sub_b),
    .i_tag (sub_req_tag),
    .i_val (sub_req_val),
    .o_rdy (sub_req_rdy),
    .o_r   (sub_r),
    .o_tag (sub_rsp_tag),
    .o_val (sub_rsp_val),
    .i_rdy (sub_rsp_rdy)
  );

endmodule

`default_nettype wire

// ==== design/ec_point_dbl.sv ====
// Jacobian point doubling scheduler, curve with a = 0
// Issues the fifteen tagged field operations to the multiplier, adder and
// subtractor as soon as their inputs are ready, and writes results back by tag
// A point with z = 0 is the point at infinity and is passed straight through

`timescale 1ns/1ns
`default_nettype none

module ec_point_dbl (
  input  wire              i_clk,
  input  wire              i_rst,
  // Input point
  input  wire ec_pkg::fe_t  i_x,
  input  wire ec_pkg::fe_t  i_y,
  input  wire ec_pkg::fe_t  i_z,
  input  wire              i_val,
  output logic             o_rdy,
  // Output point
  output ec_pkg::fe_t      o_x,
  output ec_pkg::fe_t      o_y,
  output ec_pkg::fe_t      o_z,
  output logic             o_val,
  input  wire              i_rdy,
  // Multiplier
  output ec_pkg::fe_t      o_mul_a,
  output ec_pkg::fe_t      o_mul_b,
  output ec_pkg::tag_t     o_mul_tag,
  output logic             o_mul_val,
  input  wire              i_mul_rdy,
  input  wire ec_pkg::fe_t  i_mul_r,
  input  wire ec_pkg::tag_t i_mul_tag,
  input  wire              i_mul_val,
  output logic             o_mul_rdy,
  // Adder
  output ec_pkg::fe_t      o_add_a,
  output ec_pkg::fe_t      o_add_b,
  output ec_pkg::tag_t     o_add_tag,
  output logic             o_add_val,
  input  wire              i_add_rdy,
  input  wire ec_pkg::fe_t  i_add_r,
  input  wire ec_pkg::tag_t i_add_tag,
  input  wire              i_add_val,
  output logic             o_add_rdy,
  // Subtractor
  output ec_pkg::fe_t      o_sub_a,
  output ec_pkg::fe_t      o_sub_b,
  output ec_pkg::tag_t     o_sub_tag,
  output logic             o_sub_val,
  input  wire              i_sub_rdy,
  input  wire ec_pkg::fe_t  i_sub_r,
  input  wire ec_pkg::tag_t i_sub_tag,
  input  wire              i_sub_val,
  output logic             o_sub_rdy
);

  // Plain residues, no Montgomery scaling
  localparam ec_pkg::fe_t CONST_3 = 16'd3;
  localparam ec_pkg::fe_t CONST_4 = 16'd4;
  localparam ec_pkg::fe_t CONST_8 = 16'd8;

  // Equation list, dependencies in brackets
  //  0  A  = y*y             8  E  = B+B [2]
  //  1  B  = x*A [0]         9  X3 = X3-E [8,7]
  //  2  B  = B*4 [1]        10  Y3 = B-X3 [9,2]
  //  3  C  = A*A [0]        11  Y3 = D*Y3 [10,6]
  //  4  C  = C*8 [3]        12  Y3 = Y3-C [11,4]
  //  5  D  = x*x            13  Z3 = y+y
  //  6  D  = 3*D [5]        14  Z3 = z*Z3 [13]
  //  7  X3 = D*D [6]

  ec_pkg::dbl_state_t state;

  logic [ec_pkg::NUM_EQ-1:0] eq_iss;  // Sent to a unit
  logic [ec_pkg::NUM_EQ-1:0] eq_val;  // Result written back

  ec_pkg::fe_t x_l, y_l, z_l;  // Latched input point
  ec_pkg::fe_t tmp_a, tmp_b, tmp_c, tmp_d, tmp_e;

  // Issue selection per unit
  ec_pkg::tag_t mul_sel, add_sel, sub_sel;
  logic         mul_hit, add_hit, sub_hit;
  logic         mul_go, add_go, sub_go;
  logic [2*ec_pkg::FE_W-1:0] mul_ops, add_ops, sub_ops;  // {a, b}

  logic accept;

  assign accept = (state == ec_pkg::IDLE) && i_val && o_rdy;

  // Result channels open only while running
  assign o_mul_rdy = (state == ec_pkg::RUN);
  assign o_add_rdy = (state == ec_pkg::RUN);
  assign o_sub_rdy = (state == ec_pkg::RUN);

  // Multiplier priority order
  always_comb begin
    mul_hit = 1'b1;
    mul_sel = '0;
    if (!eq_iss[0])                                  mul_sel = 4'd0;
    else if (eq_val[0] && !eq_iss[1])                mul_sel = 4'd1;
    else if (eq_val[0] && !eq_iss[3])                mul_sel = 4'd3;
    else if (!eq_iss[5])                             mul_sel = 4'd5;
    else if (eq_val[5] && !eq_iss[6])                mul_sel = 4'd6;
    else if (eq_val[6] && !eq_iss[7])                mul_sel = 4'd7;
    else if (eq_val[10] && eq_val[6] && !eq_iss[11]) mul_sel = 4'd11;
    else if (eq_val[13] && !eq_iss[14])              mul_sel = 4'd14;
    else if (eq_val[1] && !eq_iss[2])                mul_sel = 4'd2;
    else if (eq_val[3] && !eq_iss[4])                mul_sel = 4'd4;
    else                                             mul_hit = 1'b0;
    case (mul_sel)
      4'd0:    mul_ops = {y_l, y_l};
      4'd1:    mul_ops = {x_l, tmp_a};
      4'd2:    mul_ops = {tmp_b, CONST_4};
      4'd3:    mul_ops = {tmp_a, tmp_a};
      4'd4:    mul_ops = {tmp_c, CONST_8};
      4'd5:    mul_ops = {x_l, x_l};
      4'd6:    mul_ops = {CONST_3, tmp_d};
      4'd7:    mul_ops = {tmp_d, tmp_d};
      4'd11:   mul_ops = {tmp_d, o_y};
      4'd14:   mul_ops = {z_l, o_z};
      default: mul_ops = '0;
    endcase
  end

  // Subtractor priority order
  always_comb begin
    sub_hit = 1'b1;
    sub_sel = '0;
    if (eq_val[8] && eq_val[7] && !eq_iss[9])        sub_sel = 4'd9;
    else if (eq_val[9] && eq_val[2] && !eq_iss[10])  sub_sel = 4'd10;
    else if (eq_val[4] && eq_val[11] && !eq_iss[12]) sub_sel = 4'd12;
    else                                             sub_hit = 1'b0;
    case (sub_sel)
      4'd9:    sub_ops = {o_x, tmp_e};
      4'd10:   sub_ops = {tmp_b, o_x};
      4'd12:   sub_ops = {o_y, tmp_c};
      default: sub_ops = '0;
    endcase
  end

  // Adder only ever doubles
  always_comb begin
    add_hit = 1'b1;
    add_sel = '0;
    if (eq_val[2] && !eq_iss[8]) add_sel = 4'd8;
    else if (!eq_iss[13])        add_sel = 4'd13;
    else                         add_hit = 1'b0;
    case (add_sel)
      4'd8:    add_ops = {tmp_b, tmp_b};
      4'd13:   add_ops = {y_l, y_l};
      default: add_ops = '0;
    endcase
  end

  // Issue when the request register is empty or draining
  assign mul_go = (state == ec_pkg::RUN) && mul_hit && (!o_mul_val || i_mul_rdy);
  assign add_go = (state == ec_pkg::RUN) && add_hit && (!o_add_val || i_add_rdy);
  assign sub_go = (state == ec_pkg::RUN) && sub_hit && (!o_sub_val || i_sub_rdy);

  // Control state
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      state     <= ec_pkg::IDLE;
      o_rdy     <= 1'b0;
      o_val     <= 1'b0;
      o_mul_val <= 1'b0;
      o_add_val <= 1'b0;
      o_sub_val <= 1'b0;
      eq_iss    <= '0;
      eq_val    <= '0;
    end else begin
      if (o_mul_val && i_mul_rdy) o_mul_val <= 1'b0;  // Taken by unit
      if (o_add_val && i_add_rdy) o_add_val <= 1'b0;
      if (o_sub_val && i_sub_rdy) o_sub_val <= 1'b0;

      if (mul_go) begin
        o_mul_val       <= 1'b1;
        eq_iss[mul_sel] <= 1'b1;
      end
      if (add_go) begin
        o_add_val       <= 1'b1;
        eq_iss[add_sel] <= 1'b1;
      end
      if (sub_go) begin
        o_sub_val       <= 1'b1;
        eq_iss[sub_sel] <= 1'b1;
      end

      // Results mark their equation done
      if (i_mul_val && o_mul_rdy) eq_val[i_mul_tag] <= 1'b1;
      if (i_add_val && o_add_rdy) eq_val[i_add_tag] <= 1'b1;
      if (i_sub_val && o_sub_rdy) eq_val[i_sub_tag] <= 1'b1;

      case (state)
        ec_pkg::IDLE: begin
          eq_iss <= '0;
          eq_val <= '0;
          o_rdy  <= 1'b1;
          if (accept) begin
            o_rdy <= 1'b0;
            if (i_z == '0) begin
              state <= ec_pkg::DONE;  // Point at infinity
              o_val <= 1'b1;
            end else begin
              state <= ec_pkg::RUN;
            end
          end
        end
        ec_pkg::RUN: begin
          if (&eq_val) begin
            state <= ec_pkg::DONE;
            o_val <= 1'b1;
          end
        end
        ec_pkg::DONE: begin
          if (i_rdy) begin  // Output taken
            state <= ec_pkg::IDLE;
            o_val <= 1'b0;
          end
        end
        default: state <= ec_pkg::IDLE;
      endcase
    end
  end

  // Operands, temporaries and output coordinates
  always_ff @(posedge i_clk) begin
    if (accept) begin
      x_l <= i_x;
      y_l <= i_y;
      z_l <= i_z;
      o_x <= i_x;  // Kept as is for z = 0
      o_y <= i_y;
      o_z <= i_z;
    end

    if (mul_go) begin
      o_mul_a   <= mul_ops[2*ec_pkg::FE_W-1:ec_pkg::FE_W];
      o_mul_b   <= mul_ops[ec_pkg::FE_W-1:0];
      o_mul_tag <= mul_sel;
    end
    if (add_go) begin
      o_add_a   <= add_ops[2*ec_pkg::FE_W-1:ec_pkg::FE_W];
      o_add_b   <= add_ops[ec_pkg::FE_W-1:0];
      o_add_tag <= add_sel;
    end
    if (sub_go) begin
      o_sub_a   <= sub_ops[2*ec_pkg::FE_W-1:ec_pkg::FE_W];
      o_sub_b   <= sub_ops[ec_pkg::FE_W-1:0];
      o_sub_tag <= sub_sel;
    end

    if (i_mul_val && o_mul_rdy) begin
      case (i_mul_tag)
        4'd0:       tmp_a <= i_mul_r;
        4'd1, 4'd2: tmp_b <= i_mul_r;
        4'd3, 4'd4: tmp_c <= i_mul_r;
        4'd5, 4'd6: tmp_d <= i_mul_r;
        4'd7:       o_x   <= i_mul_r;
        4'd11:      o_y   <= i_mul_r;
        4'd14:      o_z   <= i_mul_r;
        default:    ;
      endcase
    end

    if (i_add_val && o_add_rdy) begin
      case (i_add_tag)
        4'd8:    tmp_e <= i_add_r;
        4'd13:   o_z   <= i_add_r;
        default: ;
      endcase
    end

    if (i_sub_val && o_sub_rdy) begin
      case (i_sub_tag)
        4'd9:        o_x <= i_sub_r;
        4'd10, 4'd12: o_y <= i_sub_r;
        default:     ;
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== design/fp_mod_addsub.sv ====
// Modular adder or subtractor
// IS_SUB picks a-b, otherwise a+b, with one correction by p
// Result and tag sit in a single output register with valid/ready

`timescale 1ns/1ns
`default_nettype none

module fp_mod_addsub #(
  parameter bit IS_SUB = 1'b0  // 1 for the subtractor
) (
  input  wire              i_clk,
  input  wire              i_rst,
  input  wire ec_pkg::fe_t  i_a,
  input  wire ec_pkg::fe_t  i_b,
  input  wire ec_pkg::tag_t i_tag,
  input  wire              i_val,
  output logic             o_rdy,
  output ec_pkg::fe_t      o_r,
  output ec_pkg::tag_t     o_tag,
  output logic             o_val,
  input  wire              i_rdy
);

  logic [ec_pkg::FE_W:0] sum;   // Carry in top bit
  logic [ec_pkg::FE_W:0] diff;  // Borrow in top bit
  ec_pkg::fe_t           res;

  always_comb begin
    sum  = {1'b0, i_a} + {1'b0, i_b};
    diff = {1'b0, i_a} - {1'b0, i_b};
    if (IS_SUB) begin
      // Borrow means a < b, wrap back by p
      res = diff[ec_pkg::FE_W] ? diff[ec_pkg::FE_W-1:0] + ec_pkg::FP_MOD
                               : diff[ec_pkg::FE_W-1:0];
    end else begin
      res = (sum >= ec_pkg::FP_MOD) ? ec_pkg::fe_t'(sum - ec_pkg::FP_MOD)
                                    : sum[ec_pkg::FE_W-1:0];
    end
  end

  // Output register free or being emptied this cycle
  assign o_rdy = !o_val || i_rdy;

  always_ff @(posedge i_clk) begin
    if (i_rst)
      o_val <= 1'b0;
    else if (o_rdy)
      o_val <= i_val;
  end

  always_ff @(posedge i_clk) begin
    if (i_val && o_rdy) begin
      o_r   <= res;
      o_tag <= i_tag;
    end
  end

endmodule

`default_nettype wire

// ==== design/fp_mod_mul.sv ====
// Pipelined modular multiplier
// Three stages: raw product, Barrett estimate and remainder, final correction
// Tag and valid travel with the data, one shared enable stalls the pipe

`timescale 1ns/1ns
`default_nettype none

module fp_mod_mul (
  input  wire              i_clk,
  input  wire              i_rst,
  // Request side
  input  wire ec_pkg::fe_t  i_a,
  input  wire ec_pkg::fe_t  i_b,
  input  wire ec_pkg::tag_t i_tag,
  input  wire              i_val,
  output logic             o_rdy,
  // Response side
  output ec_pkg::fe_t      o_r,
  output ec_pkg::tag_t     o_tag,
  output logic             o_val,
  input  wire              i_rdy
);

  logic en;  // Advance all stages

  // Stage 1 registers
  ec_pkg::wide_t s1_prod;
  ec_pkg::tag_t  s1_tag;
  logic          s1_val;

  // Stage 2 registers and inputs
  logic [3*ec_pkg::FE_W-1:0] qmul;  // Product times mu, below 2^48
  ec_pkg::fe_t               q_est;
  logic [ec_pkg::FE_W+1:0]   rem_n; // Remainder below 3p
  logic [ec_pkg::FE_W+1:0]   s2_rem;
  ec_pkg::tag_t              s2_tag;
  logic                      s2_val;

  // Stage 3 correction
  logic [ec_pkg::FE_W+1:0] red1;
  ec_pkg::fe_t             red2;

  // Whole pipe freezes while the last stage is held
  assign en    = !o_val || i_rdy;
  assign o_rdy = en;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      s1_val <= 1'b0;
      s2_val <= 1'b0;
      o_val  <= 1'b0;
    end else if (en) begin
      s1_val <= i_val;   // Bubble when no request
      s2_val <= s1_val;
      o_val  <= s2_val;
    end
  end

  always_comb begin
    qmul  = s1_prod * ec_pkg::BARRETT_MU;
    q_est = qmul[3*ec_pkg::FE_W-1:2*ec_pkg::FE_W];  // Quotient, low by at most 2
    // True remainder fits in 18 bits, so truncation is exact
    rem_n = (ec_pkg::FE_W+2)'(s1_prod - q_est * ec_pkg::FP_MOD);
  end

  // Up to two subtractions of p
  always_comb begin
    red1 = (s2_rem >= ec_pkg::FP_MOD) ? s2_rem - ec_pkg::FP_MOD : s2_rem;
    if (red1 >= ec_pkg::FP_MOD)
      red2 = ec_pkg::fe_t'(red1 - ec_pkg::FP_MOD);
    else
      red2 = ec_pkg::fe_t'(red1);
  end

  // Payload follows the shared enable
  always_ff @(posedge i_clk) begin
    if (en) begin
      s1_prod <= i_a * i_b;  // Stage 1
      s1_tag  <= i_tag;
      s2_rem  <= rem_n;      // Stage 2
      s2_tag  <= s1_tag;
      o_r     <= red2;       // Stage 3
      o_tag   <= s2_tag;
    end
  end

endmodule

`default_nettype wire

// ==== design/ec_pkg.sv ====
// EC doubling package
// Shared field, tag and state definitions for the point doubling core
// over the 16-bit prime field with modulus 65521

`default_nettype none

package ec_pkg;

  localparam int FE_W   = 16;  // Field element width
  localparam int TAG_W  = 4;   // Equation tag width
  localparam int NUM_EQ = 15;  // Equations per doubling

  typedef logic [FE_W-1:0]   fe_t;    // Field element
  typedef logic [2*FE_W-1:0] wide_t;  // Full product before reduction
  typedef logic [TAG_W-1:0]  tag_t;   // Equation tag

  // Largest 16-bit prime
  localparam fe_t FP_MOD = 16'd65521;

  // floor(2^32 / 65521), needs 17 bits
  localparam logic [FE_W:0] BARRETT_MU = 17'd65551;

  // Scheduler states
  typedef enum logic [1:0] {
    IDLE,  // Waiting for a point
    RUN,   // Issuing and collecting operations
    DONE   // Result held until taken
  } dbl_state_t;

endpackage

`default_nettype wire
